/* design/rv_pkg.sv */
package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  // Branch funct3 codes
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;
  localparam logic [2:0] f3_blt = 3'b100;
  localparam logic [2:0] f3_bge = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  typedef enum logic {src_a_rs1, src_a_pc} src_a_t;
  typedef enum logic {src_b_rs2, src_b_imm} src_b_t;
  typedef enum logic {res_alu, res_mem} result_src_t;

  typedef enum logic [1:0] {
    st_idle,
    st_decode,
    st_execute,
    st_writeback
  } fsm_state_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_t;

endpackage

/* design/fetch_decode_if.sv */
`timescale 1ns/1ps

interface fetch_decode_if;
  logic           valid;  // One-cycle instruction strobe
  rv_pkg::instr_t instr;
  logic           idle;   // Stage can take a new word

  modport fetch (
    output valid, instr,
    input  idle
  );

  modport decode (
    input  valid, instr,
    output idle
  );
endinterface

/* design/decode_exec_if.sv */
`timescale 1ns/1ps

interface decode_exec_if;
  logic                    ex_valid;
  rv_pkg::alu_op_t         alu_op;
  rv_pkg::src_a_t          src_a;
  rv_pkg::src_b_t          src_b;
  logic                    mem_read;
  logic                    mem_write;
  logic [2:0]              funct3;
  logic [rv_pkg::xlen-1:0] rd1;
  logic [rv_pkg::xlen-1:0] rd2;
  logic [rv_pkg::xlen-1:0] imm;
  logic                    pc_update;
  logic                    branch_taken;

  // Result path back from execute
  logic                    result_valid;
  logic [rv_pkg::xlen-1:0] alu_result;
  logic [rv_pkg::xlen-1:0] mem_data;
  logic                    zero_flag;

  modport decode (
    output ex_valid, alu_op, src_a, src_b, mem_read, mem_write, funct3,
    output rd1, rd2, imm, pc_update, branch_taken,
    input  result_valid, alu_result, mem_data, zero_flag
  );

  modport exec (
    input  ex_valid, alu_op, src_a, src_b, mem_read, mem_write, funct3,
    input  rd1, rd2, imm, pc_update, branch_taken,
    output result_valid, alu_result, mem_data, zero_flag
  );
endinterface

/* design/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
  input  rv_pkg::instr_t                instr,
  output rv_pkg::opcode_t               opcode,
  output logic [rv_pkg::reg_addr_w-1:0] rd,
  output logic [rv_pkg::reg_addr_w-1:0] rs1,
  output logic [rv_pkg::reg_addr_w-1:0] rs2,
  output logic [2:0]                    funct3,
  output rv_pkg::alu_op_t               alu_op,
  output rv_pkg::src_a_t                src_a,
  output rv_pkg::src_b_t                src_b,
  output logic [rv_pkg::xlen-1:0]       imm,
  output logic                          reg_write,
  output logic                          mem_read,
  output logic                          mem_write,
  output logic                          is_branch,
  output logic                          is_jump
);

  logic            alt;       // Instruction bit 30
  rv_pkg::alu_op_t arith_op;
  rv_pkg::alu_op_t cmp_op;

  assign opcode = rv_pkg::opcode_t'(instr.r_fmt.opcode);
  assign rd     = instr.r_fmt.rd;
  assign rs1    = instr.r_fmt.rs1;
  assign rs2    = instr.r_fmt.rs2;
  assign funct3 = instr.r_fmt.funct3;
  assign alt    = instr.r_fmt.funct7[5];

  always_comb begin
    case (funct3)
      3'b000:  arith_op = (alt && opcode == rv_pkg::opc_op) ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  arith_op = rv_pkg::alu_sll;
      3'b010:  arith_op = rv_pkg::alu_slt;
      3'b011:  arith_op = rv_pkg::alu_sltu;
      3'b100:  arith_op = rv_pkg::alu_xor;
      3'b101:  arith_op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  arith_op = rv_pkg::alu_or;
      default: arith_op = rv_pkg::alu_and;
    endcase
  end

  always_comb begin
    case (funct3)
      rv_pkg::f3_blt, rv_pkg::f3_bge:   cmp_op = rv_pkg::alu_slt;
      rv_pkg::f3_bltu, rv_pkg::f3_bgeu: cmp_op = rv_pkg::alu_sltu;
      default:                          cmp_op = rv_pkg::alu_sub; // beq, bne use zero
    endcase
  end

  always_comb begin
    imm       = '0;
    alu_op    = rv_pkg::alu_add;
    src_a     = rv_pkg::src_a_rs1;
    src_b     = rv_pkg::src_b_imm;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    is_branch = 1'b0;
    is_jump   = 1'b0;
    case (opcode)
      rv_pkg::opc_lui, rv_pkg::opc_auipc: begin
        imm       = {instr.u_fmt.imm_31_12, 12'b0};
        src_a     = (opcode == rv_pkg::opc_auipc) ? rv_pkg::src_a_pc : rv_pkg::src_a_rs1;
        reg_write = 1'b1;
      end
      rv_pkg::opc_jal: begin
        imm = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
               instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
        src_a     = rv_pkg::src_a_pc;
        reg_write = 1'b1;
        is_jump   = 1'b1;
      end
      rv_pkg::opc_jalr, rv_pkg::opc_load, rv_pkg::opc_op_imm: begin
        imm       = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
        reg_write = 1'b1;
        is_jump   = opcode == rv_pkg::opc_jalr;
        mem_read  = opcode == rv_pkg::opc_load;
        if (opcode == rv_pkg::opc_op_imm) alu_op = arith_op;
      end
      rv_pkg::opc_store: begin
        imm       = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
        mem_write = 1'b1;
      end
      rv_pkg::opc_branch: begin
        imm = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
               instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
        alu_op    = cmp_op;
        src_b     = rv_pkg::src_b_rs2;
        is_branch = 1'b1;
      end
      rv_pkg::opc_op: begin
        alu_op    = arith_op;
        src_b     = rv_pkg::src_b_rs2;
        reg_write = 1'b1;
      end
      default: ;  // Unsupported opcodes decode as a no-op
    endcase
  end

endmodule

/* design/control_fsm.sv */
`timescale 1ns/1ps

module control_fsm (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  input  logic                    reg_write_in,
  input  logic                    mem_read_in,
  input  logic                    is_branch,
  input  logic                    is_jump,
  input  logic [2:0]              funct3,
  input  logic                    result_valid,
  input  logic                    zero_flag,
  input  logic [rv_pkg::xlen-1:0] alu_result,
  input  logic [rv_pkg::xlen-1:0] mem_data,
  output logic                    idle,
  output logic                    wb_en,
  output logic [rv_pkg::xlen-1:0] wb_data,
  output logic                    pc_update,
  output logic                    branch_taken
);

  rv_pkg::fsm_state_t  state;
  rv_pkg::fsm_state_t  state_next;
  rv_pkg::result_src_t result_src;
  logic                reg_write_q;
  logic                mem_read_q;
  logic                is_branch_q;
  logic                is_jump_q;
  logic [2:0]          funct3_q;
  logic                busy;
  logic                done;
  logic                cond;

  assign busy = state == rv_pkg::st_decode || state == rv_pkg::st_execute;
  assign done = busy && result_valid;

  // Writeback state already accepts the next word
  assign idle = state == rv_pkg::st_idle || state == rv_pkg::st_writeback;

  assign result_src = mem_read_q ? rv_pkg::res_mem : rv_pkg::res_alu;
  assign wb_data    = (result_src == rv_pkg::res_mem) ? mem_data : alu_result;
  assign wb_en      = done && reg_write_q;
  assign pc_update  = state == rv_pkg::st_writeback && branch_taken;

  always_comb begin
    case (funct3_q)
      rv_pkg::f3_beq:                   cond = zero_flag;
      rv_pkg::f3_bne:                   cond = !zero_flag;
      rv_pkg::f3_blt, rv_pkg::f3_bltu:  cond = alu_result[0];  // slt result
      rv_pkg::f3_bge, rv_pkg::f3_bgeu:  cond = !alu_result[0];
      default:                          cond = 1'b0;
    endcase
  end

  always_comb begin
    state_next = state;
    case (state)
      rv_pkg::st_idle: begin
        if (start) state_next = rv_pkg::st_decode;
      end
      rv_pkg::st_decode: begin
        state_next = result_valid ? rv_pkg::st_writeback : rv_pkg::st_execute;
      end
      rv_pkg::st_execute: begin
        if (result_valid) state_next = rv_pkg::st_writeback;
      end
      default: begin
        state_next = start ? rv_pkg::st_decode : rv_pkg::st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= rv_pkg::st_idle;
      reg_write_q  <= 1'b0;
      mem_read_q   <= 1'b0;
      is_branch_q  <= 1'b0;
      is_jump_q    <= 1'b0;
      funct3_q     <= '0;
      branch_taken <= 1'b0;
    end else begin
      state <= state_next;
      if (start) begin
        reg_write_q  <= reg_write_in;
        mem_read_q   <= mem_read_in;
        is_branch_q  <= is_branch;
        is_jump_q    <= is_jump;
        funct3_q     <= funct3;
        branch_taken <= 1'b0;  // Cleared by the next decode
      end else if (done) begin
        branch_taken <= is_jump_q || (is_branch_q && cond);
      end
    end
  end

endmodule

/* design/register_file.sv */
`timescale 1ns/1ps

module register_file (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
  input  logic [rv_pkg::reg_addr_w-1:0] rd_addr,
  input  logic                          we,
  input  logic [rv_pkg::xlen-1:0]       wd,
  output logic [rv_pkg::xlen-1:0]       rd1,
  output logic [rv_pkg::xlen-1:0]       rd2
);

  // x0 has no storage
  logic [rv_pkg::xlen-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_addr != '0) begin
      regs[rd_addr] <= wd;
    end
  end

  assign rd1 = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rd2 = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
  input  logic           clk,
  input  logic           reset,
  fetch_decode_if.decode fd,
  decode_exec_if.decode  dx
);

  rv_pkg::opcode_t               opcode;
  logic [rv_pkg::reg_addr_w-1:0] rd;
  logic [rv_pkg::reg_addr_w-1:0] rs1;
  logic [rv_pkg::reg_addr_w-1:0] rs2;
  logic [rv_pkg::reg_addr_w-1:0] rs1_sel;
  logic [rv_pkg::reg_addr_w-1:0] wb_rd;    // Destination held until write-back
  logic [2:0]                    funct3;
  rv_pkg::alu_op_t               alu_op;
  rv_pkg::src_a_t                src_a;
  rv_pkg::src_b_t                src_b;
  logic [rv_pkg::xlen-1:0]       imm;
  logic                          reg_write;
  logic                          mem_read;
  logic                          mem_write;
  logic                          is_branch;
  logic                          is_jump;
  logic                          start;
  logic                          fsm_idle;
  logic                          wb_en;
  logic [rv_pkg::xlen-1:0]       wb_data;
  logic [rv_pkg::xlen-1:0]       rd1;
  logic [rv_pkg::xlen-1:0]       rd2;

  assign start   = fd.valid && fsm_idle;
  assign fd.idle = fsm_idle;

  // lui has immediate bits in the rs1 field, so read x0
  assign rs1_sel = (opcode == rv_pkg::opc_lui) ? '0 : rs1;

  instr_decoder dec_i (
    .instr(fd.instr), .opcode(opcode), .rd(rd), .rs1(rs1), .rs2(rs2), .funct3(funct3),
    .alu_op(alu_op), .src_a(src_a), .src_b(src_b), .imm(imm), .reg_write(reg_write),
    .mem_read(mem_read), .mem_write(mem_write), .is_branch(is_branch), .is_jump(is_jump)
  );

  control_fsm fsm_i (
    .clk(clk), .reset(reset), .start(start), .reg_write_in(reg_write),
    .mem_read_in(mem_read), .is_branch(is_branch), .is_jump(is_jump), .funct3(funct3),
    .result_valid(dx.result_valid), .zero_flag(dx.zero_flag), .alu_result(dx.alu_result),
    .mem_data(dx.mem_data), .idle(fsm_idle), .wb_en(wb_en), .wb_data(wb_data),
    .pc_update(dx.pc_update), .branch_taken(dx.branch_taken)
  );

  register_file rf_i (
    .clk(clk), .reset(reset), .rs1_addr(rs1_sel), .rs2_addr(rs2), .rd_addr(wb_rd),
    .we(wb_en), .wd(wb_data), .rd1(rd1), .rd2(rd2)
  );

  always_ff @(posedge clk) begin
    if (start) wb_rd <= rd;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dx.ex_valid  <= 1'b0;
      dx.mem_read  <= 1'b0;
      dx.mem_write <= 1'b0;
    end else begin
      dx.ex_valid  <= start;
      dx.mem_read  <= start && mem_read;   // Strobes align with ex_valid
      dx.mem_write <= start && mem_write;
    end
  end

  // Payload follows the decoder every cycle
  always_ff @(posedge clk) begin
    dx.alu_op <= alu_op;
    dx.src_a  <= src_a;
    dx.src_b  <= src_b;
    dx.funct3 <= funct3;
    dx.rd1    <= rd1;
    dx.rd2    <= rd2;
    dx.imm    <= imm;
  end

endmodule

/* design/decode_top.sv */
`timescale 1ns/1ps

module decode_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    instr_valid,
  input  logic [rv_pkg::xlen-1:0] instr,
  output logic                    idle,
  output logic                    ex_valid,
  output rv_pkg::alu_op_t         alu_op,
  output rv_pkg::src_a_t          src_a,
  output rv_pkg::src_b_t          src_b,
  output logic                    mem_read,
  output logic                    mem_write,
  output logic [2:0]              funct3,
  output logic [rv_pkg::xlen-1:0] rd1,
  output logic [rv_pkg::xlen-1:0] rd2,
  output logic [rv_pkg::xlen-1:0] imm,
  input  logic                    result_valid,
  input  logic [rv_pkg::xlen-1:0] alu_result,
  input  logic [rv_pkg::xlen-1:0] mem_data,
  input  logic                    zero_flag,
  output logic                    pc_update,
  output logic                    branch_taken
);

  fetch_decode_if fd_if ();
  decode_exec_if  dx_if ();

  // Fetch side
  assign fd_if.valid = instr_valid;
  assign fd_if.instr = instr;
  assign idle        = fd_if.idle;

  // Execute side
  assign ex_valid           = dx_if.ex_valid;
  assign alu_op             = dx_if.alu_op;
  assign src_a              = dx_if.src_a;
  assign src_b              = dx_if.src_b;
  assign mem_read           = dx_if.mem_read;
  assign mem_write          = dx_if.mem_write;
  assign funct3             = dx_if.funct3;
  assign rd1                = dx_if.rd1;
  assign rd2                = dx_if.rd2;
  assign imm                = dx_if.imm;
  assign pc_update          = dx_if.pc_update;
  assign branch_taken       = dx_if.branch_taken;
  assign dx_if.result_valid = result_valid;
  assign dx_if.alu_result   = alu_result;
  assign dx_if.mem_data     = mem_data;
  assign dx_if.zero_flag    = zero_flag;

  decode_stage stage_i (
    .clk   (clk),
    .reset (reset),
    .fd    (fd_if.decode),
    .dx    (dx_if.decode)
  );

endmodule

/* test/decode_chk.sv */
`timescale 1ns/1ps

module decode_chk (
  input logic clk,
  input logic reset,
  input logic instr_valid,
  input logic idle,
  input logic ex_valid,
  input logic pc_update
);

  // Bundle goes out one cycle after an accepted word, and never otherwise
  ex_valid_follows_start: assert property (
    @(posedge clk) disable iff (reset)
    ex_valid == $past(instr_valid && idle)
  ) else $error("ex_valid does not follow the strobe accepted one cycle earlier");

  no_strobe_while_busy: assert property (
    @(posedge clk) disable iff (reset)
    !(instr_valid && !idle)
  ) else $error("instr_valid strobed while the stage was busy");

  single_pc_update: assert property (
    @(posedge clk) disable iff (reset)
    pc_update |=> !pc_update
  ) else $error("pc_update stayed high for two cycles");

endmodule

/* test/decode_tb.sv */
`timescale 1ns/1ps

module decode_tb;

  typedef struct {
    logic [31:0] instr;
    int          delay;    // Cycles from the strobe to result_valid
    logic [31:0] alu_res;
    logic [31:0] mem_dat;
    logic        zero;
    logic [3:0]  op;
    logic        sa;
    logic        sb;
    logic [31:0] imm;
    logic        mr;
    logic        mw;
    logic        pc;       // Expected pc_update
  } row_t;

  logic clk;
  logic reset;
  logic instr_valid;
  logic result_valid;
  logic zero_flag;
  logic idle;
  logic ex_valid;
  logic mem_read;
  logic mem_write;
  logic pc_update;
  logic branch_taken;
  logic [31:0] instr;
  logic [31:0] alu_result;
  logic [31:0] mem_data;
  logic [31:0] rd1;
  logic [31:0] rd2;
  logic [31:0] imm;
  logic [2:0]  funct3;
  rv_pkg::alu_op_t alu_op;
  rv_pkg::src_a_t  src_a;
  rv_pkg::src_b_t  src_b;

  row_t        rows[$];
  logic [31:0] shadow [32] = '{default: '0};  // Register file model
  logic [31:0] lfsr_state = 32'd89;
  int          errors;
  int          row_errs;
  int          rows_ok;
  int          rows_bad;
  int          cycles;
  int          limit;

  decode_top dut_i (.*);

  bind decode_top decode_chk chk_i (
    .clk(clk), .reset(reset), .instr_valid(instr_valid), .idle(idle),
    .ex_valid(ex_valid), .pc_update(pc_update)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  // ISA bit placement of the S, B and J immediates
  function automatic logic [31:0] s_word(input logic [11:0] im, input logic [4:0] rs2, rs1);
    return {im[11:5], rs2, rs1, 3'b010, im[4:0], rv_pkg::opc_store};
  endfunction

  function automatic logic [31:0] b_word(input logic [12:0] im, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
    return {im[12], im[10:5], rs2, rs1, f3, im[4:1], im[11], rv_pkg::opc_branch};
  endfunction

  function automatic logic [31:0] j_word(input logic [20:0] im, input logic [4:0] rd);
    return {im[20], im[10:1], im[11], im[19:12], rd, rv_pkg::opc_jal};
  endfunction

  task automatic add_row(input logic [31:0] ins, input int dly, input logic [31:0] ar, md,
                         input logic z, input logic [3:0] op, input logic sa, sb,
                         input logic [31:0] im, input logic mr, mw, pc);
    rows.push_back(row_t'{ins, dly, ar, md, z, op, sa, sb, im, mr, mw, pc});
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
      row_errs++;
    end
  endtask

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] exp_rd1;
    logic [31:0] exp_rd2;
    logic [6:0]  opc;
    logic [4:0]  rd_idx;
    reset = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    result_valid = 1'b0;
    alu_result = '0;
    mem_data = '0;
    zero_flag = 1'b0;

    r = rand_bits(12);
    add_row({r[11:0], 5'd3, 3'b000, 5'd5, rv_pkg::opc_op_imm}, 1, rand_bits(32), 0, 0,
            rv_pkg::alu_add, 0, 1, {{20{r[11]}}, r[11:0]}, 0, 0, 0);
    add_row({7'b0100000, 5'd5, 5'd2, 3'b000, 5'd6, rv_pkg::opc_op}, 2, rand_bits(32), 0, 0,
            rv_pkg::alu_sub, 0, 0, 0, 0, 0, 0);
    add_row({7'b0100000, 5'd3, 5'd6, 3'b101, 5'd7, rv_pkg::opc_op_imm}, 3, rand_bits(32),
            0, 0, rv_pkg::alu_sra, 0, 1, 32'h403, 0, 0, 0);
    r = rand_bits(12);
    add_row({r[11:0], 5'd5, 3'b010, 5'd10, rv_pkg::opc_load}, 2, rand_bits(32), rand_bits(32),
            0, rv_pkg::alu_add, 0, 1, {{20{r[11]}}, r[11:0]}, 1, 0, 0);
    r = rand_bits(12);
    add_row(s_word(r[11:0], 5'd10, 5'd6), 1, rand_bits(32), 0, 0, rv_pkg::alu_add, 0, 1,
            {{20{r[11]}}, r[11:0]}, 0, 1, 0);
    add_row({12'd1, 5'd5, 3'b000, 5'd0, rv_pkg::opc_op_imm}, 1, rand_bits(32) | 1, 0, 0,
            rv_pkg::alu_add, 0, 1, 32'd1, 0, 0, 0);  // Write to x0
    add_row({7'b0, 5'd10, 5'd0, 3'b110, 5'd11, rv_pkg::opc_op}, 2, rand_bits(32), 0, 0,
            rv_pkg::alu_or, 0, 0, 0, 0, 0, 0);
    r = rand_bits(20);
    add_row({r[19:0], 5'd12, rv_pkg::opc_lui}, 1, rand_bits(32), 0, 0, rv_pkg::alu_add, 0, 1,
            {r[19:0], 12'b0}, 0, 0, 0);
    r = rand_bits(20);
    add_row({r[19:0], 5'd13, rv_pkg::opc_auipc}, 3, rand_bits(32), 0, 0, rv_pkg::alu_add, 1,
            1, {r[19:0], 12'b0}, 0, 0, 0);
    r = rand_bits(20);
    add_row(j_word({r[19:0], 1'b0}, 5'd1), 2, rand_bits(32), 0, 0, rv_pkg::alu_add, 1, 1,
            {{11{r[19]}}, r[19:0], 1'b0}, 0, 0, 1);
    r = rand_bits(12);
    add_row({r[11:0], 5'd1, 3'b000, 5'd0, rv_pkg::opc_jalr}, 1, rand_bits(32), 0, 0,
            rv_pkg::alu_add, 0, 1, {{20{r[11]}}, r[11:0]}, 0, 0, 1);
    r = rand_bits(12);
    add_row(b_word({r[11:0], 1'b0}, 5'd5, 5'd5, rv_pkg::f3_beq), 1, rand_bits(32), 0, 1,
            rv_pkg::alu_sub, 0, 0, {{19{r[11]}}, r[11:0], 1'b0}, 0, 0, 1);
    r = rand_bits(12);
    add_row(b_word({r[11:0], 1'b0}, 5'd6, 5'd5, rv_pkg::f3_bne), 3, rand_bits(32), 0, 1,
            rv_pkg::alu_sub, 0, 0, {{19{r[11]}}, r[11:0], 1'b0}, 0, 0, 0);
    r = rand_bits(12);
    add_row(b_word({r[11:0], 1'b0}, 5'd5, 5'd6, rv_pkg::f3_blt), 2, 32'h1, 0, 0,
            rv_pkg::alu_slt, 0, 0, {{19{r[11]}}, r[11:0], 1'b0}, 0, 0, 1);
    r = rand_bits(12);
    add_row(b_word({r[11:0], 1'b0}, 5'd8, 5'd7, rv_pkg::f3_bgeu), 1, 32'h1, 0, 0,
            rv_pkg::alu_sltu, 0, 0, {{19{r[11]}}, r[11:0], 1'b0}, 0, 0, 0);
    limit = rows.size() * 8 + 8 + 20;

    repeat (8) step();
    reset = 1'b0;
    check("idle", idle, 1);
    check("ex_valid", ex_valid, 0);
    check("pc_update", pc_update, 0);
    check("mem_read", mem_read, 0);
    check("mem_write", mem_write, 0);

    foreach (rows[k]) begin
      row_errs = 0;
      opc = rows[k].instr[6:0];
      rd_idx = rows[k].instr[11:7];
      while (!idle) step();
      exp_rd1 = (opc == rv_pkg::opc_lui) ? '0 : shadow[rows[k].instr[19:15]];
      exp_rd2 = shadow[rows[k].instr[24:20]];
      instr = rows[k].instr;
      instr_valid = 1'b1;
      step();
      instr_valid = 1'b0;
      check("ex_valid", ex_valid, 1);
      check("alu_op", alu_op, rows[k].op);
      check("src_a", src_a, rows[k].sa);
      check("src_b", src_b, rows[k].sb);
      check("funct3", funct3, rows[k].instr[14:12]);
      check("imm", imm, rows[k].imm);
      check("rd1", rd1, exp_rd1);
      check("rd2", rd2, exp_rd2);
      check("mem_read", mem_read, rows[k].mr);
      check("mem_write", mem_write, rows[k].mw);
      check("idle", idle, 0);
      repeat (rows[k].delay - 1) step();
      result_valid = 1'b1;
      alu_result = rows[k].alu_res;
      mem_data = rows[k].mem_dat;
      zero_flag = rows[k].zero;
      step();
      result_valid = 1'b0;
      check("pc_update", pc_update, rows[k].pc);
      check("branch_taken", branch_taken, rows[k].pc);
      check("idle", idle, 1);
      // Branches and stores leave the registers alone
      if (opc != rv_pkg::opc_store && opc != rv_pkg::opc_branch && rd_idx != 0)
        shadow[rd_idx] = rows[k].mr ? rows[k].mem_dat : rows[k].alu_res;
      if (row_errs == 0) rows_ok++;
      else rows_bad++;
      $display("row %0d instr %h: %s", k, rows[k].instr, (row_errs == 0) ? "pass" : "fail");
    end

    $display("Rows passed %0d, rows failed %0d, check errors %0d", rows_ok, rows_bad, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
design/rv_pkg.sv
design/fetch_decode_if.sv
design/decode_exec_if.sv
design/instr_decoder.sv
design/control_fsm.sv
design/register_file.sv
design/decode_stage.sv
design/decode_top.sv
test/decode_chk.sv
test/decode_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= decode_tb
RTL_TOP    ?= decode_top
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= ALL TESTS PASSED
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
